// File: all.f
src/spi_pkg.sv
src/byte_rx.sv
src/cmd_decoder.sv
src/readback_mux.sv
src/tx_shifter.sv
src/spi_peripheral.sv
test/tb_clock.sv
test/spi_peripheral_asserts.sv
test/tb_spi_peripheral.sv

// File: src/byte_rx.sv
/*
 * serial to parallel byte assembly, msb first
 * raises rx_valid for one cycle after the eighth bit
 */
`timescale 1ns/1ns

module byte_rx (
    input  logic           sclk,
    input  logic           rstn,
    input  logic           sel,        // frames the transaction
    input  logic           serial_in,
    output spi_pkg::byte_t rx_byte,
    output logic           rx_valid
);
    import spi_pkg::*;

    bit_cnt_t bit_cnt;  // bits taken so far in the current byte

    // data path, shifts only inside a frame
    always_ff @(posedge sclk) begin
        if (sel) begin
            rx_byte <= {rx_byte[6:0], serial_in};  // first bit ends up in bit 7
        end
    end

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else if (!sel) begin
            bit_cnt  <= '0;                       // restart byte framing
            rx_valid <= 1'b0;
        end else begin
            bit_cnt  <= bit_cnt + 1'b1;           // wraps to 0 after bit 7
            rx_valid <= (bit_cnt == '1);          // eighth bit taken this edge
        end
    end

endmodule

// File: src/cmd_decoder.sv
/*
 * address pointer and write decode
 * holds the trigger mask, instruction and mode registers
 */
`timescale 1ns/1ns

module cmd_decoder (
    input  logic           sclk,
    input  logic           rstn,
    input  logic           sel,
    input  spi_pkg::byte_t rx_byte,
    input  logic           rx_valid,
    output spi_pkg::addr_t pointer,
    output spi_pkg::byte_t trigger_channel_mask,
    output spi_pkg::byte_t instruction,
    output spi_pkg::byte_t mode
);
    import spi_pkg::*;

    logic ptr_set;  // byte sets the pointer
    logic wr_en;    // byte is data for the register at pointer

    assign ptr_set = sel && rx_valid && (pointer == '0);
    assign wr_en   = sel && rx_valid && (pointer != '0);

    // first byte of a frame loads the pointer, later bytes step it
    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            pointer <= '0;
        end else if (!sel) begin
            pointer <= '0;
        end else if (ptr_set) begin
            pointer <= addr_t'(rx_byte);
        end else if (wr_en) begin
            pointer <= pointer + 1'b1;
        end
    end

    // configuration registers keep their value across frames
    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            trigger_channel_mask <= '0;
            instruction          <= '0;
            mode                 <= '0;
        end else if (wr_en) begin
            case (pointer)
                ADDR_TRIGGER_MASK: trigger_channel_mask <= rx_byte;
                ADDR_INSTRUCTION:  instruction          <= rx_byte;
                ADDR_MODE:         mode                 <= rx_byte;
                default: ;  // read only or unmapped, pointer still steps
            endcase
        end
    end

endmodule

// File: src/readback_mux.sv
/*
 * read data selection by pointer
 * configuration bytes plus channel words cut into lsb first bytes
 */
`timescale 1ns/1ns

module readback_mux #(
    parameter int NUM_CHANNELS = 8,
    parameter int CH_WIDTH     = 50
) (
    input  spi_pkg::addr_t                   pointer,
    input  spi_pkg::byte_t                   trigger_channel_mask,
    input  spi_pkg::byte_t                   instruction,
    input  spi_pkg::byte_t                   mode,
    input  logic [NUM_CHANNELS*CH_WIDTH-1:0] channel_data,  // channel 0 in the low bits
    output spi_pkg::byte_t                   read_byte
);
    import spi_pkg::*;

    localparam int BYTES_PER_CH   = (CH_WIDTH + 7) / 8;      // 7 for 50 bit words
    localparam int CH_BITS_PADDED = BYTES_PER_CH * 8;
    localparam int NUM_BYTES      = NUM_CHANNELS * BYTES_PER_CH;

    logic [NUM_BYTES*8-1:0] byte_map;   // every channel padded up to whole bytes
    addr_t                  ch_offset;  // byte index into byte_map
    logic                   in_ch_map;

    // pad each channel word with zeros above CH_WIDTH
    always_comb begin
        byte_map = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            byte_map[c*CH_BITS_PADDED +: CH_WIDTH] = channel_data[c*CH_WIDTH +: CH_WIDTH];
        end
    end

    assign ch_offset = pointer - FIRST_CHANNEL_ADDR;
    assign in_ch_map = (pointer >= FIRST_CHANNEL_ADDR) && (int'(ch_offset) < NUM_BYTES);

    always_comb begin
        case (pointer)
            ADDR_TRIGGER_MASK: read_byte = trigger_channel_mask;
            ADDR_INSTRUCTION:  read_byte = instruction;
            ADDR_MODE:         read_byte = mode;
            default: begin
                if (in_ch_map) begin
                    read_byte = byte_map[int'(ch_offset)*8 +: 8];
                end else begin
                    read_byte = '0;  // address 0 and past the map
                end
            end
        endcase
    end

endmodule

// File: src/spi_peripheral.sv
/*
 * spi peripheral top level
 * byte receive, command decode, readback select and transmit shifter
 */
`timescale 1ns/1ns

module spi_peripheral #(
    parameter int NUM_CHANNELS = 8,
    parameter int CH_WIDTH     = 50
) (
    input  logic                             sclk,
    input  logic                             rstn,
    input  logic                             sel,
    input  logic                             serial_in,
    input  logic [NUM_CHANNELS*CH_WIDTH-1:0] channel_data,
    output logic                             serial_out,
    output spi_pkg::byte_t                   trigger_channel_mask,
    output spi_pkg::byte_t                   instruction,
    output spi_pkg::byte_t                   mode
);
    import spi_pkg::*;

    byte_t rx_byte;    // assembled byte from serial_in
    logic  rx_valid;   // one cycle strobe per byte
    addr_t pointer;    // current register address
    byte_t read_byte;  // data at pointer, before the update

    byte_rx u_byte_rx (
        .sclk      (sclk),
        .rstn      (rstn),
        .sel       (sel),
        .serial_in (serial_in),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    cmd_decoder u_cmd_decoder (
        .sclk                 (sclk),
        .rstn                 (rstn),
        .sel                  (sel),
        .rx_byte              (rx_byte),
        .rx_valid             (rx_valid),
        .pointer              (pointer),
        .trigger_channel_mask (trigger_channel_mask),
        .instruction          (instruction),
        .mode                 (mode)
    );

    // combinational, follows pointer
    readback_mux #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .CH_WIDTH     (CH_WIDTH)
    ) u_readback_mux (
        .pointer              (pointer),
        .trigger_channel_mask (trigger_channel_mask),
        .instruction          (instruction),
        .mode                 (mode),
        .channel_data         (channel_data),
        .read_byte            (read_byte)
    );

    // loads on the same edge that the decoder acts on the byte
    tx_shifter u_tx_shifter (
        .sclk       (sclk),
        .rstn       (rstn),
        .sel        (sel),
        .read_byte  (read_byte),
        .rx_valid   (rx_valid),
        .serial_out (serial_out)
    );

endmodule

// File: src/spi_pkg.sv
/*
 * shared types and register map for the spi peripheral
 * byte, address and bit counter widths, writable register addresses
 */
package spi_pkg;

    // data byte as it travels on serial_in and serial_out
    typedef logic [7:0] byte_t;

    // register address and the pointer that walks the map
    typedef logic [7:0] addr_t;

    typedef logic [2:0] bit_cnt_t;  // bit position inside a byte

    // writable configuration registers
    localparam addr_t ADDR_TRIGGER_MASK = 8'd1;
    localparam addr_t ADDR_INSTRUCTION  = 8'd2;
    localparam addr_t ADDR_MODE         = 8'd3;

    // read only channel bytes start here, lsb byte of channel 0 first
    localparam addr_t FIRST_CHANNEL_ADDR = 8'd4;

endpackage

// File: src/tx_shifter.sv
/*
 * output shift register for serial_out
 * loads on rx_valid, sends lsb first with zero fill
 */
`timescale 1ns/1ns

module tx_shifter (
    input  logic           sclk,
    input  logic           rstn,
    input  logic           sel,
    input  spi_pkg::byte_t read_byte,
    input  logic           rx_valid,   // load strobe
    output logic           serial_out
);
    import spi_pkg::*;

    byte_t shift_q;

    // a new load overwrites whatever bits are left
    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            shift_q <= '0;
        end else if (!sel) begin
            shift_q <= '0;
        end else if (rx_valid) begin
            shift_q <= read_byte;
        end else begin
            shift_q <= {1'b0, shift_q[7:1]};  // next bit moves into bit 0
        end
    end

    assign serial_out = shift_q[0];

endmodule

// File: test/spi_peripheral_asserts.sv
/*
 * reference model of the register map, bound to spi_peripheral
 * concurrent assertions on configuration outputs and serial_out
 */
`timescale 1ns/1ns

module spi_peripheral_asserts #(
    parameter int NUM_CHANNELS = 8,
    parameter int CH_WIDTH     = 50
) (
    input logic                             sclk,
    input logic                             rstn,
    input logic                             sel,
    input logic                             serial_in,
    input logic [NUM_CHANNELS*CH_WIDTH-1:0] channel_data,
    input logic                             serial_out,
    input spi_pkg::byte_t                   trigger_channel_mask,
    input spi_pkg::byte_t                   instruction,
    input spi_pkg::byte_t                   mode
);
    import spi_pkg::*;

    localparam int BYTES_PER_CH = (CH_WIDTH + 7) / 8;

    int unsigned fail_count = 0;  // read by the testbench at the end
    int unsigned sel_edges;       // rising edges seen inside the frame
    byte_t       m_shift;
    logic        m_byte_done;     // a full byte sits in m_shift
    addr_t       m_ptr;
    byte_t       m_mask;
    byte_t       m_instr;
    byte_t       m_mode;
    byte_t       m_tx;            // byte expected in the current readback slot
    bit_cnt_t    m_slot_bit;
    logic        m_slot_on;

    // register map as seen from the serial side
    function automatic byte_t model_read(input addr_t addr);
        int    idx;
        int    ch;
        int    bit_pos;
        byte_t val;
        val = '0;
        if (addr == ADDR_TRIGGER_MASK) begin
            val = m_mask;
        end else if (addr == ADDR_INSTRUCTION) begin
            val = m_instr;
        end else if (addr == ADDR_MODE) begin
            val = m_mode;
        end else if (addr >= FIRST_CHANNEL_ADDR) begin
            idx = int'(addr) - int'(FIRST_CHANNEL_ADDR);
            ch  = idx / BYTES_PER_CH;
            if (ch < NUM_CHANNELS) begin
                for (int j = 0; j < 8; j++) begin
                    bit_pos = (idx % BYTES_PER_CH) * 8 + j;
                    if (bit_pos < CH_WIDTH) begin
                        val[j] = channel_data[ch*CH_WIDTH + bit_pos];
                    end
                end
            end
        end
        return val;
    endfunction

    always @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            sel_edges   <= 0;
            m_byte_done <= 1'b0;
            m_ptr       <= '0;
            m_mask      <= '0;
            m_instr     <= '0;
            m_mode      <= '0;
            m_tx        <= '0;
            m_slot_bit  <= '0;
            m_slot_on   <= 1'b0;
        end else if (!sel) begin
            sel_edges   <= 0;
            m_byte_done <= 1'b0;
            m_ptr       <= '0;
            m_slot_on   <= 1'b0;
        end else begin
            m_shift     <= {m_shift[6:0], serial_in};
            sel_edges   <= sel_edges + 1;
            m_byte_done <= (sel_edges % 8 == 7);  // edge 8k+8
            if (m_slot_on) begin
                m_slot_bit <= m_slot_bit + 1'b1;
                if (m_slot_bit == 3'd7) m_slot_on <= 1'b0;
            end
            // edge 8k+9, read at the old pointer then act on the byte
            if (m_byte_done) begin
                m_tx       <= model_read(m_ptr);
                m_slot_on  <= 1'b1;
                m_slot_bit <= '0;
                if (m_ptr == '0) begin
                    m_ptr <= m_shift;
                end else begin
                    m_ptr <= m_ptr + 1'b1;
                    if (m_ptr == ADDR_TRIGGER_MASK) m_mask <= m_shift;
                    if (m_ptr == ADDR_INSTRUCTION) m_instr <= m_shift;
                    if (m_ptr == ADDR_MODE) m_mode <= m_shift;
                end
            end
        end
    end

    cfg_follows_writes: assert property (@(posedge sclk) disable iff (!rstn)
        trigger_channel_mask == m_mask && instruction == m_instr && mode == m_mode)
    else begin
        $error("ERR %0t: configuration outputs differ from the model", $time);
        fail_count++;
    end

    readback_slot: assert property (@(posedge sclk) disable iff (!rstn)
        m_slot_on |-> serial_out == m_tx[m_slot_bit])
    else begin
        $error("ERR %0t: serial_out bit %0d of readback %02h is wrong", $time, m_slot_bit, m_tx);
        fail_count++;
    end

    idle_after_deselect: assert property (@(posedge sclk) disable iff (!rstn)
        !sel |=> !serial_out)
    else begin
        $error("ERR %0t: serial_out is not low after sel dropped", $time);
        fail_count++;
    end

    known_serial_out: assert property (@(posedge sclk) disable iff (!rstn)
        !$isunknown(serial_out))
    else begin
        $error("ERR %0t: serial_out is unknown", $time);
        fail_count++;
    end

endmodule

bind spi_peripheral spi_peripheral_asserts #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .CH_WIDTH     (CH_WIDTH)
) u_asserts (
    .sclk                 (sclk),
    .rstn                 (rstn),
    .sel                  (sel),
    .serial_in            (serial_in),
    .channel_data         (channel_data),
    .serial_out           (serial_out),
    .trigger_channel_mask (trigger_channel_mask),
    .instruction          (instruction),
    .mode                 (mode)
);

// File: test/tb_clock.sv
/*
 * testbench clock and reset generator
 * free running sclk, rstn held low for the first cycles
 */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic sclk,
    output logic rstn
);

    initial begin
        sclk = 1'b0;
        forever #(PERIOD_NS / 2) sclk = ~sclk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge sclk);
        rstn <= 1'b1;  // release on a rising edge
    end

endmodule

// File: test/tb_spi_peripheral.sv
/*
 * testbench for spi_peripheral
 * frame stimulus, random channel words, timeouts and closing summary
 */
`timescale 1ns/1ns

module tb_spi_peripheral;
    import spi_pkg::*;

    localparam int NUM_CHANNELS = 8;
    localparam int CH_WIDTH     = 50;
    localparam int CH_BITS      = NUM_CHANNELS * CH_WIDTH;
    localparam int WAIT_LIMIT   = 100;  // cycles per wait loop

    logic               sclk;
    logic               rstn;
    logic               sel;
    logic               serial_in;
    logic [CH_BITS-1:0] channel_data;
    logic               serial_out;
    byte_t              trigger_channel_mask;
    byte_t              instruction;
    byte_t              mode;

    byte_t       exp_mask;
    byte_t       exp_instr;
    byte_t       exp_mode;
    logic [31:0] lcg_state;
    int          errors;
    byte_t       frame[$];

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clock (.sclk(sclk), .rstn(rstn));

    spi_peripheral #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .CH_WIDTH     (CH_WIDTH)
    ) i_dut (
        .sclk                 (sclk),
        .rstn                 (rstn),
        .sel                  (sel),
        .serial_in            (serial_in),
        .channel_data         (channel_data),
        .serial_out           (serial_out),
        .trigger_channel_mask (trigger_channel_mask),
        .instruction          (instruction),
        .mode                 (mode)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_random_byte(output byte_t b);
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[23:16];  // upper bits, low bits of an lcg are weak
    endtask

    task automatic check_byte(input string what, input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s reads %02h, expected %02h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_config();
        @(negedge sclk);
        check_byte("trigger_channel_mask", trigger_channel_mask, exp_mask);
        check_byte("instruction", instruction, exp_instr);
        check_byte("mode", mode, exp_mode);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rstn !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge sclk);
            cycles++;
        end
        if (rstn !== 1'b1) begin
            $display("timeout: reset was still asserted after %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic wait_output_low();
        int cycles;
        cycles = 0;
        while (serial_out !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge sclk);
            cycles++;
        end
        if (serial_out !== 1'b0) begin
            $display("timeout: serial_out did not return low after the frame");
            errors++;
        end
    endtask

    // msb first, then 8 idle bits so the last readback slot drains
    task automatic send_frame(input byte_t data[$]);
        @(posedge sclk);
        sel <= 1'b1;
        foreach (data[n]) begin
            for (int i = 7; i >= 0; i--) begin
                serial_in <= data[n][i];
                @(posedge sclk);
            end
        end
        serial_in <= 1'b0;
        repeat (8) @(posedge sclk);
        sel <= 1'b0;
        repeat (3) @(posedge sclk);
    endtask

    task automatic send_partial(input byte_t data, input int nbits);
        @(posedge sclk);
        sel <= 1'b1;
        for (int i = 7; i > 7 - nbits; i--) begin
            serial_in <= data[i];
            @(posedge sclk);
        end
        serial_in <= 1'b0;
        sel       <= 1'b0;  // aborted byte
        repeat (3) @(posedge sclk);
    endtask

    initial begin
        byte_t              rand_b;
        logic [CH_BITS-1:0] ch_words;
        int unsigned        assert_fails;
        errors       = 0;
        sel          = 1'b0;
        serial_in    = 1'b0;
        channel_data = '0;
        lcg_state    = 32'd83;
        exp_mask     = '0;
        exp_instr    = '0;
        exp_mode     = '0;

        wait_reset_release();
        check_config();
        check_byte("serial_out after reset", {7'b0, serial_out}, 8'h00);

        for (int i = 0; i < CH_BITS; i++) begin
            lcg_state   = lcg_next(lcg_state);
            ch_words[i] = lcg_state[16];
        end
        @(posedge sclk);
        channel_data <= ch_words;

        // write with auto increment
        frame = {ADDR_TRIGGER_MASK, 8'hA5, 8'h3C, 8'h5A};
        send_frame(frame);
        exp_mask  = 8'hA5;
        exp_instr = 8'h3C;
        exp_mode  = 8'h5A;
        check_config();

        // old values come back while the new ones go in
        frame = {ADDR_TRIGGER_MASK, 8'h96, 8'h0F, 8'hC3};
        send_frame(frame);
        exp_mask  = 8'h96;
        exp_instr = 8'h0F;
        exp_mode  = 8'hC3;
        check_config();

        // all channel bytes, then two addresses past the map
        frame = {FIRST_CHANNEL_ADDR};
        repeat (NUM_CHANNELS * ((CH_WIDTH + 7) / 8) + 2) begin
            next_random_byte(rand_b);
            frame.push_back(rand_b);
        end
        send_frame(frame);
        check_config();

        // aborted byte must not shift the next frame
        send_partial(ADDR_INSTRUCTION, 5);
        check_config();
        frame = {ADDR_INSTRUCTION, 8'h77};
        send_frame(frame);
        exp_instr = 8'h77;
        check_config();

        // address 0 keeps the pointer waiting for a real address
        frame = {8'h00, 8'h00, ADDR_MODE, 8'hE1};
        send_frame(frame);
        exp_mode = 8'hE1;
        check_config();

        frame = {8'hC8, 8'h11, 8'h22};
        send_frame(frame);
        check_config();

        wait_output_low();
        assert_fails = i_dut.u_asserts.fail_count;
        $display("checks done: %0d testbench errors, %0d assertion failures",
                 errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
